// File: router_pkg.sv
// Shared types for the five-port mesh router
// Packet layout, link channel, port numbering, and the XY routing
// and hop update helpers used by RTL and the testbench model
package router_pkg;

    localparam int NUM_PORTS = 5;
    localparam int NUM_VCS   = 2;    // Even and odd

    typedef logic [2:0]           port_idx_t;
    typedef logic [NUM_PORTS-1:0] port_mask_t;   // One bit per port
    typedef logic [3:0]           hop_t;
    typedef logic                 vc_t;          // 0 even, 1 odd
    typedef logic [47:0]          payload_t;

    localparam port_idx_t PORT_PE = 3'd0;
    localparam port_idx_t PORT_N  = 3'd1;
    localparam port_idx_t PORT_E  = 3'd2;
    localparam port_idx_t PORT_S  = 3'd3;
    localparam port_idx_t PORT_W  = 3'd4;

    // 64-bit single-flit packet, top bit first
    typedef struct packed {
        logic       rsvd_top;
        logic       x_sign;      // 0 east, 1 west
        logic       y_sign;      // 0 north, 1 south
        logic [4:0] rsvd;
        hop_t       x_hops;
        hop_t       y_hops;
        payload_t   payload;
    } packet_t;

    // One direction of a link
    typedef struct packed {
        logic    send;
        packet_t data;
    } link_t;

    // XY routing, X first then Y, PE once both counts reach zero
    function automatic port_idx_t route_dir(input packet_t pkt);
        port_idx_t dir;
        if (pkt.x_hops != '0) begin
            dir = pkt.x_sign ? PORT_W : PORT_E;
        end else if (pkt.y_hops != '0) begin
            dir = pkt.y_sign ? PORT_S : PORT_N;
        end else begin
            dir = PORT_PE;
        end
        return dir;
    endfunction

    // One hop consumed on the dimension being routed
    function automatic packet_t hop_decrement(input packet_t pkt);
        packet_t res;
        res = pkt;
        if (pkt.x_hops != '0) begin
            res.x_hops = pkt.x_hops - hop_t'(1);
        end else if (pkt.y_hops != '0) begin
            res.y_hops = pkt.y_hops - hop_t'(1);
        end
        return res;
    endfunction

endpackage

// File: rr_arbiter.sv
// Round-robin arbiter
// Searches from a rotating pointer; the pointer only moves past the
// winner when more than one line was requesting
`timescale 1ns/100ps

module rr_arbiter #(
    parameter int N = 5
) (
    input  logic         clk,
    input  logic         reset,
    input  logic         enable,   // Target slot is free
    input  logic [N-1:0] req,
    output logic [N-1:0] grant
);

    localparam int PTR_W = (N > 1) ? $clog2(N) : 1;

    logic [PTR_W-1:0] ptr;
    logic [PTR_W-1:0] winner;
    logic             found;
    logic             multi_req;

    assign multi_req = (req & (req - 1'b1)) != '0;   // At least two lines set

    always_comb begin
        int idx;
        grant  = '0;
        winner = ptr;
        found  = 1'b0;
        for (int k = 0; k < N; k++) begin
            idx = (int'(ptr) + k) % N;
            if (!found && req[idx]) begin
                found  = 1'b1;
                winner = PTR_W'(idx);
            end
        end
        if (enable && found)
            grant[winner] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ptr <= '0;
        end else if (|grant && multi_req) begin
            ptr <= (winner == PTR_W'(N - 1)) ? '0 : winner + 1'b1;  // Wrap at N
        end
    end

    a_grant_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(grant) && ((grant & ~req) == '0))
        else $error("rr_arbiter: grant %b not one-hot or not requested (req %b)", grant, req);

endmodule

// File: noc_input_bank.sv
// Router input bank
// Holds the VC polarity, one slot per port and VC, takes link packets
// on the external VC and builds the XY request matrix on the internal VC
`timescale 1ns/100ps

module noc_input_bank (
    input  logic                                          clk,
    input  logic                                          reset,
    input  router_pkg::link_t    [router_pkg::NUM_PORTS-1:0] in_link,
    output router_pkg::port_mask_t                        in_ready,
    input  router_pkg::port_mask_t [router_pkg::NUM_PORTS-1:0] grant,
    output router_pkg::vc_t                               polarity,
    output router_pkg::packet_t  [router_pkg::NUM_PORTS-1:0] head_pkt,
    output router_pkg::port_mask_t [router_pkg::NUM_PORTS-1:0] req
);

    router_pkg::vc_t        ext_vc;
    router_pkg::packet_t    slot_pkt [router_pkg::NUM_PORTS][router_pkg::NUM_VCS];
    logic [router_pkg::NUM_VCS-1:0] slot_full [router_pkg::NUM_PORTS];
    router_pkg::port_mask_t wr_en;
    router_pkg::port_mask_t grant_any;
    router_pkg::port_mask_t grant_col [router_pkg::NUM_PORTS];  // Outputs granting input i

    assign ext_vc = ~polarity;   // Link-facing VC

    always_ff @(posedge clk) begin
        if (reset)
            polarity <= 1'b0;
        else
            polarity <= ~polarity;
    end

    // Link side
    always_comb begin
        for (int i = 0; i < router_pkg::NUM_PORTS; i++) begin
            in_ready[i] = ~slot_full[i][ext_vc];
            wr_en[i]    = in_link[i].send & in_ready[i];
        end
    end

    // Transpose grants so each input sees which outputs took it
    always_comb begin
        for (int i = 0; i < router_pkg::NUM_PORTS; i++) begin
            for (int o = 0; o < router_pkg::NUM_PORTS; o++)
                grant_col[i][o] = grant[o][i];
            grant_any[i] = |grant_col[i];
        end
    end

    // Accept and release never touch the same VC
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < router_pkg::NUM_PORTS; i++)
                slot_full[i] <= '0;
        end else begin
            for (int i = 0; i < router_pkg::NUM_PORTS; i++) begin
                if (wr_en[i])
                    slot_full[i][ext_vc] <= 1'b1;
                if (grant_any[i])
                    slot_full[i][polarity] <= 1'b0;   // Moved to an output slot
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < router_pkg::NUM_PORTS; i++) begin
            if (wr_en[i])
                slot_pkt[i][ext_vc] <= in_link[i].data;
        end
    end

    // Head packets and routing requests on the internal VC
    always_comb begin
        for (int o = 0; o < router_pkg::NUM_PORTS; o++)
            req[o] = '0;
        for (int i = 0; i < router_pkg::NUM_PORTS; i++) begin
            head_pkt[i] = slot_pkt[i][polarity];
            if (slot_full[i][polarity])
                req[router_pkg::route_dir(slot_pkt[i][polarity])][i] = 1'b1;
        end
    end

    for (genvar i = 0; i < router_pkg::NUM_PORTS; i++) begin : g_chk
        // A full slot keeps its packet until it is released
        for (genvar v = 0; v < router_pkg::NUM_VCS; v++) begin : g_vc
            a_no_overwrite: assert property (@(posedge clk) disable iff (reset)
                slot_full[i][v] |=> $stable(slot_pkt[i][v]))
                else $error("noc_input_bank: slot %0d VC %0d written while full", i, v);
        end

        // Only full slots get granted, and by a single output
        a_grant_valid: assert property (@(posedge clk) disable iff (reset)
            grant_any[i] |-> slot_full[i][polarity] && $onehot0(grant_col[i]))
            else $error("noc_input_bank: bad grant %b for input %0d", grant_col[i], i);
    end

endmodule

// File: noc_output_port.sv
// Router output port
// Two VC slots, one round-robin arbiter per VC, hop update on the way
// in and the link strobe on the way out
`timescale 1ns/100ps

module noc_output_port #(
    parameter bit IS_LOCAL = 1'b0   // PE output keeps hop counts
) (
    input  logic                                          clk,
    input  logic                                          reset,
    input  router_pkg::vc_t                               polarity,
    input  router_pkg::packet_t  [router_pkg::NUM_PORTS-1:0] head_pkt,
    input  router_pkg::port_mask_t                        req,
    output router_pkg::port_mask_t                        grant,
    input  logic                                          out_ready,
    output router_pkg::link_t                             out_link
);

    router_pkg::vc_t        ext_vc;
    router_pkg::packet_t    slot_pkt [router_pkg::NUM_VCS];
    logic [router_pkg::NUM_VCS-1:0] slot_full;
    router_pkg::port_mask_t vc_grant [router_pkg::NUM_VCS];
    router_pkg::packet_t    sel_pkt;
    router_pkg::packet_t    load_pkt;

    assign ext_vc = ~polarity;

    // Only the internal VC arbitrates, and only into an empty slot
    for (genvar v = 0; v < router_pkg::NUM_VCS; v++) begin : g_vc
        rr_arbiter #(
            .N (router_pkg::NUM_PORTS)
        ) u_arb (
            .clk    (clk),
            .reset  (reset),
            .enable (polarity == router_pkg::vc_t'(v) && !slot_full[v]),
            .req    (req),
            .grant  (vc_grant[v])
        );
    end

    assign grant = vc_grant[polarity];

    always_comb begin
        sel_pkt = '0;
        for (int i = 0; i < router_pkg::NUM_PORTS; i++) begin
            if (grant[i])
                sel_pkt = head_pkt[i];
        end
        load_pkt = IS_LOCAL ? sel_pkt : router_pkg::hop_decrement(sel_pkt);
    end

    // Load on internal VC, drain on external VC
    always_ff @(posedge clk) begin
        if (reset) begin
            slot_full <= '0;
        end else begin
            if (|grant)
                slot_full[polarity] <= 1'b1;
            if (out_link.send)
                slot_full[ext_vc] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (|grant)
            slot_pkt[polarity] <= load_pkt;
    end

    assign out_link.send = slot_full[ext_vc] & out_ready;
    assign out_link.data = slot_pkt[ext_vc];   // Shown even when not sending

    a_no_grant_full: assert property (@(posedge clk) disable iff (reset)
        |grant |-> !slot_full[polarity])
        else $error("noc_output_port: grant %b into full slot on VC %0d", grant, polarity);

endmodule

// File: noc_router.sv
// Five-port mesh router top
// One input bank feeding five output ports; grants return to the bank
// so the granted input slots are released on the same edge
`timescale 1ns/100ps

module noc_router (
    input  logic                                          clk,
    input  logic                                          reset,
    output router_pkg::vc_t                               polarity,
    input  router_pkg::link_t    [router_pkg::NUM_PORTS-1:0] in_link,
    output router_pkg::port_mask_t                        in_ready,
    output router_pkg::link_t    [router_pkg::NUM_PORTS-1:0] out_link,
    input  router_pkg::port_mask_t                        out_ready
);

    router_pkg::packet_t    [router_pkg::NUM_PORTS-1:0] head_pkt;   // Internal VC heads
    router_pkg::port_mask_t [router_pkg::NUM_PORTS-1:0] req;        // Indexed by output
    router_pkg::port_mask_t [router_pkg::NUM_PORTS-1:0] grant;      // Indexed by output

    noc_input_bank u_in_bank (
        .clk      (clk),
        .reset    (reset),
        .in_link  (in_link),
        .in_ready (in_ready),
        .grant    (grant),
        .polarity (polarity),
        .head_pkt (head_pkt),
        .req      (req)
    );

    // Port 0 is the PE, the rest are mesh links
    for (genvar o = 0; o < router_pkg::NUM_PORTS; o++) begin : g_out
        noc_output_port #(
            .IS_LOCAL (o == int'(router_pkg::PORT_PE))
        ) u_out (
            .clk       (clk),
            .reset     (reset),
            .polarity  (polarity),
            .head_pkt  (head_pkt),
            .req       (req[o]),
            .grant     (grant[o]),
            .out_ready (out_ready[o]),
            .out_link  (out_link[o])
        );
    end

endmodule

// File: tb_router_model.svh
// Router testbench reference model
// Galois LFSR, random packet builder and the expected-packet queues,
// one queue per output port
`ifndef TB_ROUTER_MODEL_SVH
`define TB_ROUTER_MODEL_SVH

localparam logic [31:0] LFSR_SEED = 32'd68960;
localparam logic [31:0] LFSR_TAPS = 32'hA300_0000;   // x^32 + x^30 + x^26 + x^25 + 1

typedef struct packed {
    router_pkg::vc_t     vc;          // VC at acceptance
    logic [31:0]         acc_cycle;
    router_pkg::packet_t pkt;         // As it should leave the router
} exp_entry_t;

logic [31:0] lfsr_state;
exp_entry_t  exp_q [router_pkg::NUM_PORTS][$];

function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
endfunction

// One LFSR step per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
        v          = {v[30:0], lfsr_state[0]};
        lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
endfunction

// Payload is {source port, random byte, unique tag}
function automatic router_pkg::packet_t make_packet(input router_pkg::port_idx_t src,
                                                    input logic [31:0] tag,
                                                    input logic to_pe);
    router_pkg::packet_t p;
    logic [31:0]         r;
    r          = rand_bits(20);
    p.rsvd_top = r[0];
    p.x_sign   = r[1];
    p.y_sign   = r[2];
    p.rsvd     = r[7:3];
    p.x_hops   = to_pe ? 4'd0 : {2'b00, r[9:8]};    // 0 to 3 hops
    p.y_hops   = to_pe ? 4'd0 : {2'b00, r[11:10]};
    p.payload  = {5'b00000, src, r[19:12], tag};
    return p;
endfunction

// XY model, hop count only consumed on mesh links
function automatic void expect_packet(input router_pkg::packet_t pkt,
                                      input router_pkg::vc_t vc, input int acc_cycle);
    exp_entry_t            ent;
    router_pkg::port_idx_t dir;
    dir           = router_pkg::route_dir(pkt);
    ent.vc        = vc;
    ent.acc_cycle = 32'(acc_cycle);
    ent.pkt       = (dir == router_pkg::PORT_PE) ? pkt : router_pkg::hop_decrement(pkt);
    exp_q[dir].push_back(ent);
endfunction

function automatic int find_tag(input int port, input logic [31:0] tag);
    int idx;
    idx = -1;
    for (int k = 0; k < exp_q[port].size(); k++) begin
        if (idx < 0 && exp_q[port][k].pkt.payload[31:0] == tag)
            idx = k;
    end
    return idx;
endfunction

function automatic int in_flight();
    int n;
    n = 0;
    for (int o = 0; o < router_pkg::NUM_PORTS; o++)
        n += exp_q[o].size();
    return n;
endfunction

`endif

// File: tb_noc_router.sv
// Testbench for the five-port mesh router
// Random traffic against an XY reference model, latency, back-pressure
// and round-robin fairness at the PE output
`timescale 1ns/100ps

module tb_noc_router;

    localparam int NUM_PORTS    = router_pkg::NUM_PORTS;
    localparam int RESET_CYCLES = 5;
    localparam int POL_CYCLES   = 8;
    localparam int DRAIN_CYCLES = 60;
    localparam int RAND_CYCLES  = 400;
    localparam int BP_CYCLES    = 400;
    localparam int FAIR_CYCLES  = 200;
    localparam int TOTAL_CYCLES = RESET_CYCLES + POL_CYCLES + 5 * (DRAIN_CYCLES + 3)
                                + RAND_CYCLES + BP_CYCLES + FAIR_CYCLES
                                + 3 * (DRAIN_CYCLES + 2);
    localparam int TIMEOUT_CYCLES = TOTAL_CYCLES + 200;

    localparam int MODE_IDLE   = 0;
    localparam int MODE_SINGLE = 1;
    localparam int MODE_RANDOM = 2;
    localparam int MODE_FAIR   = 3;   // Four mesh inputs all aimed at the PE

    logic                                   clk;
    logic                                   reset;
    router_pkg::vc_t                        polarity;
    router_pkg::link_t [NUM_PORTS-1:0]      in_link;
    router_pkg::port_mask_t                 in_ready;
    router_pkg::link_t [NUM_PORTS-1:0]      out_link;
    router_pkg::port_mask_t                 out_ready;

    int          cycle;
    int          value_errors;
    int          protocol_errors;
    int          seq_errors;
    int          departures;
    int          mode;
    logic        bp_en;
    logic        lat_check;
    logic        fair_check;
    logic        single_req;
    int          single_port;
    logic [31:0] next_tag;
    logic [NUM_PORTS-1:0] accepted;         // Seen at the last falling edge
    int          wait_cnt [router_pkg::NUM_VCS][NUM_PORTS];
    string       test_name;

    `include "tb_router_model.svh"

    noc_router i_dut (
        .clk       (clk),
        .reset     (reset),
        .polarity  (polarity),
        .in_link   (in_link),
        .in_ready  (in_ready),
        .out_link  (out_link),
        .out_ready (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic expect_equal(input string what, input logic [63:0] exp,
                                input logic [63:0] act);
        assert (exp === act) else begin
            value_errors++;
            $display("[FAIL] %s %s expected %0h actual %0h", test_name, what, exp, act);
        end
    endtask

    task automatic ensure(input logic cond, input string msg);
        assert (cond) else begin
            protocol_errors++;
            $display("ERROR in %s: %s", test_name, msg);
        end
    endtask

    function automatic logic offer_wanted(input int p);
        logic [31:0] r;
        logic        want;
        want = 1'b0;
        case (mode)
            MODE_RANDOM: begin
                r    = rand_bits(1);
                want = r[0];
            end
            MODE_FAIR:   want = (p != int'(router_pkg::PORT_PE));
            MODE_SINGLE: want = single_req && (single_port == p);
            default:     want = 1'b0;
        endcase
        return want;
    endfunction

    function automatic logic offers_pending();
        logic any;
        any = 1'b0;
        for (int p = 0; p < NUM_PORTS; p++)
            any |= in_link[p].send;
        return any;
    endfunction

    // Round-robin bound counted per VC at the PE output
    task automatic note_fair_delivery(input int src, input router_pkg::vc_t vc);
        wait_cnt[vc][src] = 0;
        for (int i = 1; i < NUM_PORTS; i++) begin
            if (i != src) begin
                wait_cnt[vc][i]++;
                ensure(wait_cnt[vc][i] <= NUM_PORTS - 1,
                       $sformatf("input %0d on VC %0d waited through %0d deliveries",
                                 i, vc, wait_cnt[vc][i]));
            end
        end
    endtask

    task automatic retire_packet(input int o);
        router_pkg::packet_t act;
        exp_entry_t          ent;
        logic [31:0]         tag;
        int                  idx;
        int                  port;
        act  = out_link[o].data;
        tag  = act.payload[31:0];
        port = o;
        idx  = find_tag(o, tag);
        for (int q = 0; q < NUM_PORTS; q++) begin
            if (idx < 0 && q != o) begin
                idx  = find_tag(q, tag);
                port = q;
            end
        end
        if (idx < 0) begin
            ensure(1'b0, $sformatf("output %0d sent tag %0h that is not in flight", o, tag));
        end else begin
            ent = exp_q[port][idx];
            exp_q[port].delete(idx);
            departures++;
            expect_equal("output port", 64'(port), 64'(o));
            expect_equal("packet", ent.pkt, act);
            expect_equal("vc", 64'(ent.vc), 64'(!polarity));
            if (lat_check)
                expect_equal("latency", 64'(2), 64'(cycle - int'(ent.acc_cycle)));
            if (fair_check && o == int'(router_pkg::PORT_PE))
                note_fair_delivery(int'(act.payload[42:40]), ~polarity);
        end
    endtask

    // Driver updates all DUT inputs just after the rising edge
    initial begin
        router_pkg::link_t lk;
        logic [31:0]       r;
        lfsr_state = LFSR_SEED;
        next_tag   = '0;
        in_link    = '0;
        out_ready  = '1;
        forever begin
            @(posedge clk);
            if (reset) begin
                in_link   <= '0;
                out_ready <= '1;
            end else begin
                for (int p = 0; p < NUM_PORTS; p++) begin
                    if (!in_link[p].send || accepted[p]) begin   // Offer held until taken
                        lk = '0;
                        if (offer_wanted(p)) begin
                            lk.send = 1'b1;
                            lk.data = make_packet(router_pkg::port_idx_t'(p), next_tag,
                                                  mode == MODE_FAIR);
                            next_tag++;
                        end
                        in_link[p] <= lk;
                    end
                end
                if (bp_en) begin
                    r = rand_bits(5);
                    out_ready <= r[4:0];
                end else begin
                    out_ready <= '1;
                end
            end
        end
    end

    // Monitor and model update on the falling edge
    initial begin
        router_pkg::vc_t prev_pol;
        logic            prev_reset;
        accepted   = '0;
        departures = 0;
        prev_pol   = 1'b0;
        prev_reset = 1'b1;
        value_errors    = 0;
        protocol_errors = 0;
        forever begin
            @(negedge clk);
            if (reset) begin
                accepted = '0;
                expect_equal("in_ready in reset", 64'h1f, 64'(in_ready));
                expect_equal("polarity in reset", 64'(0), 64'(polarity));
                for (int o = 0; o < NUM_PORTS; o++)
                    expect_equal("send in reset", 64'(0), 64'(out_link[o].send));
            end else begin
                if (!prev_reset)
                    expect_equal("polarity toggle", 64'(!prev_pol), 64'(polarity));
                for (int p = 0; p < NUM_PORTS; p++) begin
                    accepted[p] = in_link[p].send & in_ready[p];
                    if (accepted[p])
                        expect_packet(in_link[p].data, ~polarity, cycle);
                end
                for (int o = 0; o < NUM_PORTS; o++) begin
                    ensure(!out_link[o].send || out_ready[o],
                           $sformatf("output %0d sent while its ready was low", o));
                    if (out_link[o].send)
                        retire_packet(o);
                end
            end
            if (!fair_check)
                wait_cnt = '{default: 0};
            prev_pol   = polarity;
            prev_reset = reset;
        end
    end

    task automatic wait_drain();
        int n;
        n = 0;
        repeat (2) @(posedge clk);
        while ((in_flight() != 0 || offers_pending()) && n < DRAIN_CYCLES) begin
            @(posedge clk);
            n++;
        end
        assert (in_flight() == 0 && !offers_pending()) else begin
            seq_errors++;
            $display("ERROR in %s: %0d packets never left the router", test_name, in_flight());
        end
    endtask

    initial begin
        int dep_before;
        reset       = 1'b1;
        mode        = MODE_IDLE;
        bp_en       = 1'b0;
        lat_check   = 1'b0;
        fair_check  = 1'b0;
        single_req  = 1'b0;
        single_port = 0;
        seq_errors  = 0;
        test_name   = "reset";
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        repeat (POL_CYCLES) @(posedge clk);

        // One packet per input port into an idle router
        test_name = "single_latency";
        mode      <= MODE_SINGLE;
        lat_check <= 1'b1;
        for (int p = 0; p < NUM_PORTS; p++) begin
            dep_before = departures;
            single_port <= p;
            single_req  <= 1'b1;
            @(posedge clk);
            single_req <= 1'b0;
            wait_drain();
            assert (departures == dep_before + 1) else begin
                seq_errors++;
                $display("[FAIL] %s departures expected %0d actual %0d",
                         test_name, dep_before + 1, departures);
            end
        end
        lat_check <= 1'b0;

        test_name = "random_traffic";
        mode <= MODE_RANDOM;
        repeat (RAND_CYCLES) @(posedge clk);
        mode <= MODE_IDLE;
        wait_drain();

        test_name = "back_pressure";
        mode  <= MODE_RANDOM;
        bp_en <= 1'b1;
        repeat (BP_CYCLES) @(posedge clk);
        mode  <= MODE_IDLE;
        bp_en <= 1'b0;
        wait_drain();

        test_name  = "rr_fairness";
        dep_before = departures;
        mode       <= MODE_FAIR;
        fair_check <= 1'b1;
        repeat (FAIR_CYCLES) @(posedge clk);
        mode       <= MODE_IDLE;
        fair_check <= 1'b0;   // Inputs stop requesting from here
        wait_drain();
        assert (departures > dep_before) else begin
            seq_errors++;
            $display("ERROR in %s: no packet reached the PE output", test_name);
        end

        $display("Done: %0d value errors, %0d protocol errors, %0d sequence errors",
                 value_errors, protocol_errors, seq_errors);
        if (value_errors + protocol_errors + seq_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        cycle = 0;
        while (cycle < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle++;
        end
        $display("Timeout after %0d cycles, the tests did not finish", cycle);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: tb.f
+incdir+.
router_pkg.sv
rr_arbiter.sv
noc_input_bank.sv
noc_output_port.sv
noc_router.sv
tb_noc_router.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the router testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_noc_router -f tb.f -o sim_router

sim_out=$(./obj_dir/sim_router) || true
echo "$sim_out"

if grep -q "STATUS: PASS" <<< "$sim_out"; then
    exit 0
else
    exit 1
fi
